/* list.f */
+incdir+include
src/posit_pkg.sv
src/leading_one_detect.sv
src/barrel_shifter.sv
src/posit_decode.sv
src/posit_align_add.sv
src/posit_normalize_round.sv
src/posit_add_top.sv
verif/posit_add_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := posit_add_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/posit_add_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module posit_add_tb;

   localparam posit_pkg::posit_t NAR = `POSIT_NAR;
   localparam logic [1:0] MODE_EXACT   = 2'd0;
   localparam logic [1:0] MODE_CAPTURE = 2'd1;
   localparam logic [1:0] MODE_MATCH   = 2'd2;
   localparam int DRAIN_LIMIT = 20;

   // One pending result, due is the cycle done_o should show it
   typedef struct packed {
      posit_pkg::posit_t value;
      logic              nar;
      logic              zero;
      logic [1:0]        mode;
      logic [31:0]       due;
   } expect_t;

   logic              Clk = 1'b0;
   logic              rst;
   logic              start_i;
   posit_pkg::posit_t in1_i;
   posit_pkg::posit_t in2_i;
   posit_pkg::posit_t out_o;
   logic              p_inf_o;
   logic              p_zero_o;
   logic              done_o;

   logic [31:0]       cycle = '0;
   expect_t           pending[$];
   expect_t           head;
   posit_pkg::posit_t captured;
   int                checks = 0;
   int                errors = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   int                test_errors_base;
   int                test_checks_base;

   posit_add_top u_posit_add_top (
      .Clk     (Clk),
      .rst     (rst),
      .start_i (start_i),
      .in1_i   (in1_i),
      .in2_i   (in2_i),
      .out_o   (out_o),
      .p_inf_o (p_inf_o),
      .p_zero_o(p_zero_o),
      .done_o  (done_o)
   );

   // 20 ns period
   always #10 Clk = ~Clk;

   always @(posedge Clk) cycle <= cycle + 1;

   ////////////////////////////////////////////////////////////
   // Reference and checks
   ////////////////////////////////////////////////////////////

   // Exact posit of a small integer, es = 2
   function automatic posit_pkg::posit_t encode_int(input int value);
      posit_pkg::posit_t word;
      int                mag;
      int                scale;
      int                k;
      int                pos;
      int                i;
      word = '0;
      if (value == 0)
         return word;
      mag   = (value < 0) ? -value : value;
      scale = 0;
      while ((mag >> (scale + 1)) != 0)
         scale++;
      k   = scale / 4;
      pos = 30;
      // Run of k+1 ones, then the terminating zero
      for (i = 0; i <= k; i++)
      begin
         word[pos] = 1'b1;
         pos--;
      end
      word[pos] = 1'b0;
      pos--;
      // Two exponent bits
      word[pos] = scale[1];
      pos--;
      word[pos] = scale[0];
      pos--;
      // Fraction bits below the leading one
      for (i = scale - 1; i >= 0; i--)
      begin
         word[pos] = mag[i];
         pos--;
      end
      if (value < 0)
         word = -word;
      return word;
   endfunction

   // Any word except zero and NaR
   function automatic posit_pkg::posit_t random_real();
      posit_pkg::posit_t word;
      do
         word = $urandom;
      while (word == '0 || word == NAR);
      return word;
   endfunction

   task automatic check_posit(input string name, input posit_pkg::posit_t got,
                              input posit_pkg::posit_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Outputs are settled by the falling edge
   always @(negedge Clk)
   begin
      if (!rst && done_o)
      begin
         if (pending.size() == 0)
         begin
            errors++;
            $display("Error at %0t ns: done_o pulsed with no operation pending", $time);
         end
         else
         begin
            head = pending.pop_front();
            if (cycle != head.due)
            begin
               errors++;
               $display("Error at %0t ns: done_o came at cycle %0d instead of cycle %0d",
                        $time, cycle, head.due);
            end
            case (head.mode)
               MODE_CAPTURE: captured = out_o;
               MODE_MATCH:   check_posit("out_o", out_o, captured);
               default:      check_posit("out_o", out_o, head.value);
            endcase
            check_flag("p_inf_o", p_inf_o, head.nar);
            check_flag("p_zero_o", p_zero_o, head.zero);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   // Called 1 ns after a rising edge, returns 1 ns after the next
   task automatic send(input posit_pkg::posit_t a, input posit_pkg::posit_t b,
                       input posit_pkg::posit_t value, input logic [1:0] mode);
      expect_t entry;
      entry.value = value;
      entry.nar   = (a == NAR) || (b == NAR);
      entry.zero  = (a == '0) && (b == '0);
      entry.mode  = mode;
      entry.due   = cycle + 2;
      in1_i   = a;
      in2_i   = b;
      start_i = 1'b1;
      pending.push_back(entry);
      @(posedge Clk);
      #1;
      start_i = 1'b0;
   endtask

   task automatic idle(input int count);
      repeat (count)
      begin
         @(posedge Clk);
         #1;
      end
   endtask

   task automatic begin_test();
      test_errors_base = errors;
      test_checks_base = checks;
   endtask

   // Drain the scoreboard, then one line for the test
   task automatic end_test(input string name);
      int waited;
      waited = 0;
      while (pending.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge Clk);
         #1;
         waited++;
      end
      if (pending.size() != 0)
      begin
         errors++;
         $display("Timeout in %s: %0d results never arrived", name, pending.size());
         pending.delete();
      end
      tests_run++;
      if (errors != test_errors_base)
         tests_failed++;
      $display("Test %s: %0d checks, %0d errors", name, checks - test_checks_base,
               errors - test_errors_base);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      int                a;
      int                b;
      int                i;
      posit_pkg::posit_t x;
      posit_pkg::posit_t y;
      void'($urandom(32'h48bd_8b81));
      rst     = 1'b1;
      start_i = 1'b0;
      in1_i   = '0;
      in2_i   = '0;
      repeat (3) @(posedge Clk);
      #1;

      // Registers still hold reset values here
      begin_test();
      check_posit("out_o", out_o, '0);
      check_flag("p_inf_o", p_inf_o, 1'b0);
      check_flag("p_zero_o", p_zero_o, 1'b0);
      check_flag("done_o", done_o, 1'b0);
      rst = 1'b0;
      // Three back to back, then a lone pulse
      send(32'h4000_0000, 32'h4000_0000, 32'h4800_0000, MODE_EXACT);
      send(32'h4000_0000, 32'h4000_0000, 32'h4800_0000, MODE_EXACT);
      send(32'h4000_0000, 32'h4000_0000, 32'h4800_0000, MODE_EXACT);
      idle(3);
      send(32'h4000_0000, 32'h4000_0000, 32'h4800_0000, MODE_EXACT);
      end_test("reset_latency");

      begin_test();
      send(NAR, encode_int(3), NAR, MODE_EXACT);
      send(encode_int(-5), NAR, NAR, MODE_EXACT);
      send(NAR, NAR, NAR, MODE_EXACT);
      send(NAR, '0, NAR, MODE_EXACT);
      send('0, '0, '0, MODE_EXACT);
      end_test("special_values");

      // Full sweep, cancelling pairs skipped
      begin_test();
      for (a = -64; a <= 64; a++)
      begin
         for (b = -64; b <= 64; b++)
         begin
            if (a + b != 0)
               send(encode_int(a), encode_int(b), encode_int(a + b), MODE_EXACT);
         end
      end
      end_test("integer_sums");

      begin_test();
      for (i = 0; i < 200; i++)
      begin
         x = random_real();
         send(x, '0, x, MODE_EXACT);
         send('0, x, x, MODE_EXACT);
         send(x, -x, '0, MODE_EXACT);
      end
      end_test("identity_cancel");

      // Swapped pair right behind, so both are in flight
      begin_test();
      for (i = 0; i < 200; i++)
      begin
         x = $urandom;
         y = $urandom;
         send(x, y, '0, MODE_CAPTURE);
         send(y, x, '0, MODE_MATCH);
      end
      end_test("commutativity");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* src/posit_add_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module posit_add_top (
   input  logic              Clk,
   input  logic              rst,
   input  logic              start_i,
   input  posit_pkg::posit_t in1_i,
   input  posit_pkg::posit_t in2_i,
   output posit_pkg::posit_t out_o,
   output logic              p_inf_o,
   output logic              p_zero_o,
   output logic              done_o
);

   posit_pkg::posit_t        in1_q;
   posit_pkg::posit_t        in2_q;
   logic                     start_q;
   posit_pkg::posit_t        in1_mag;
   posit_pkg::posit_t        in2_mag;
   posit_pkg::posit_fields_t fields_1;
   posit_pkg::posit_fields_t fields_2;
   posit_pkg::posit_sum_t    sum;
   posit_pkg::posit_t        result;
   logic                     nar;
   logic                     zero;

   // Input stage
   always_ff @(posedge Clk)
   begin
      if (rst)
      begin
         in1_q   <= '0;
         in2_q   <= '0;
         start_q <= 1'b0;
      end
      else
      begin
         in1_q   <= in1_i;
         in2_q   <= in2_i;
         start_q <= start_i;
      end
   end

   // Magnitudes for the operand order compare
   assign in1_mag = in1_q[`POSIT_N-1] ? -in1_q : in1_q;
   assign in2_mag = in2_q[`POSIT_N-1] ? -in2_q : in2_q;

   posit_decode u_decode_1 (
      .word_i  (in1_q),
      .fields_o(fields_1)
   );

   posit_decode u_decode_2 (
      .word_i  (in2_q),
      .fields_o(fields_2)
   );

   posit_align_add u_align_add (
      .a_i    (fields_1),
      .b_i    (fields_2),
      .a_mag_i(in1_mag),
      .b_mag_i(in2_mag),
      .sum_o  (sum)
   );

   posit_normalize_round u_normalize_round (
      .sum_i   (sum),
      .a_i     (in1_q),
      .b_i     (in2_q),
      .result_o(result),
      .nar_o   (nar),
      .zero_o  (zero)
   );

   // Output stage, done follows start by two edges
   always_ff @(posedge Clk)
   begin
      if (rst)
      begin
         out_o    <= '0;
         p_inf_o  <= 1'b0;
         p_zero_o <= 1'b0;
         done_o   <= 1'b0;
      end
      else
      begin
         out_o    <= result;
         p_inf_o  <= nar;
         p_zero_o <= zero;
         done_o   <= start_q;
      end
   end

endmodule

`default_nettype wire

/* src/posit_normalize_round.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module posit_normalize_round (
   input  posit_pkg::posit_sum_t sum_i,
   input  posit_pkg::posit_t     a_i,
   input  posit_pkg::posit_t     b_i,
   output posit_pkg::posit_t     result_o,
   output logic                  nar_o,
   output logic                  zero_o
);

   localparam int N  = `POSIT_N;
   localparam int ES = `POSIT_ES;
   localparam int BS = `POSIT_BS;
   localparam int SW = `POSIT_SCALE_W;
   // Packed word plus a word of room below for round bits
   localparam int PW = 3*N + 3;

   logic [BS-1:0]    lead_zeros;
   logic             nonzero;
   logic [N-1:0]     norm_raw;
   logic [N-1:0]     norm;
   logic [SW:0]      scale_out;
   logic [SW-1:0]    scale_mag;
   logic [SW-ES:0]   run_raw;
   logic [BS-1:0]    run_lim;
   logic [BS-1:0]    run_len;
   logic [2*N+2:0]   pack_word;
   logic [PW-1:0]    placed;
   logic [N-2:0]     kept;
   logic             guard_bit;
   logic             round_bit;
   logic             sticky;
   logic             round_up;
   logic [N-2:0]     rounded;
   logic [N-2:0]     mag_out;
   logic             nar_a;
   logic             nar_b;

   ////////////////////////////////////////////////////////////
   // Normalize
   ////////////////////////////////////////////////////////////

   // Carry and hidden positions share the top detector bit
   // Lowest sum bit is dropped, so a one there alone is a cancel
   leading_one_detect #(.WIDTH(N)) u_lod (
      .in_i   ({sum_i.sum[N] | sum_i.sum[N-1], sum_i.sum[N-2:1], 1'b0}),
      .count_o(lead_zeros),
      .valid_o(nonzero)
   );

   barrel_shifter #(.WIDTH(N), .SHIFT_LEFT(1'b1)) u_shl (
      .data_i  (sum_i.sum[N:1]),
      .amount_i(lead_zeros),
      .data_o  (norm_raw)
   );

   // No carry leaves the leading one a place low
   assign norm = norm_raw[N-1] ? norm_raw : {norm_raw[N-2:0], 1'b0};

   // One bit wider so tiny results cannot wrap positive
   assign scale_out = {sum_i.scale[SW-1], sum_i.scale}
                      - {{(SW+1-BS){1'b0}}, lead_zeros}
                      + {{SW{1'b0}}, sum_i.sum[N]};

   ////////////////////////////////////////////////////////////
   // Regime and exponent
   ////////////////////////////////////////////////////////////

   assign scale_mag = scale_out[SW] ? -scale_out[SW-1:0] : scale_out[SW-1:0];

   // Run length
   // ones run is k+1, zeros run is -k rounded toward minus infinity
   assign run_raw = (~scale_out[SW] | (|scale_mag[ES-1:0]))
                    ? {1'b0, scale_mag[SW-1:ES]} + 1'b1
                    : {1'b0, scale_mag[SW-1:ES]};

   // Clamp to maxpos and minpos
   assign run_lim = scale_out[SW] ? BS'(N-2) : BS'(N-1);
   assign run_len = (run_raw > run_lim) ? run_lim : run_raw[BS-1:0];

   // Regime fill, terminator, exponent, fraction below the hidden bit
   assign pack_word = {{N{~scale_out[SW]}}, scale_out[SW], scale_out[ES-1:0],
                       norm[N-2:0], {(3-ES){1'b0}}};

   // Shift pushes the regime run in from the top
   barrel_shifter #(.WIDTH(PW), .SHIFT_LEFT(1'b0)) u_shr (
      .data_i  ({pack_word, {N{1'b0}}}),
      .amount_i(run_len),
      .data_o  (placed)
   );

   ////////////////////////////////////////////////////////////
   // Round to nearest even
   ////////////////////////////////////////////////////////////

   assign kept      = placed[2*N+2:N+4];
   assign guard_bit = placed[N+3];
   assign round_bit = placed[N+2];
   assign sticky    = |placed[N+1:0];
   // Ties go up only from an odd LSB
   assign round_up  = guard_bit & (round_bit | sticky | kept[0]);

   // Long regimes leave no fraction to round
   assign rounded = (run_len < N-ES-2) ? kept + round_up : kept;

   // Negative results in two's complement below the sign
   assign mag_out = sum_i.sign ? -rounded : rounded;

   ////////////////////////////////////////////////////////////
   // Specials
   ////////////////////////////////////////////////////////////

   assign nar_a  = a_i[N-1] & ~(|a_i[N-2:0]);
   assign nar_b  = b_i[N-1] & ~(|b_i[N-2:0]);
   assign nar_o  = nar_a | nar_b;
   assign zero_o = ~(|a_i) & ~(|b_i);

   // NaR first, then zero operands or a full cancel
   assign result_o = nar_o ? `POSIT_NAR
                   : (zero_o | ~nonzero) ? '0
                   : {sum_i.sign, mag_out};

endmodule

`default_nettype wire

/* src/posit_align_add.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module posit_align_add (
   input  posit_pkg::posit_fields_t a_i,
   input  posit_pkg::posit_fields_t b_i,
   input  posit_pkg::posit_t        a_mag_i,
   input  posit_pkg::posit_t        b_mag_i,
   output posit_pkg::posit_sum_t    sum_o
);

   localparam int N  = `POSIT_N;
   localparam int BS = `POSIT_BS;
   localparam int SW = `POSIT_SCALE_W;

   posit_pkg::posit_fields_t op_big;
   posit_pkg::posit_fields_t op_sml;
   logic                     a_big;
   logic [SW-1:0]            big_scale;
   logic [SW-1:0]            sml_scale;
   logic [SW-1:0]            scale_diff;
   logic [BS-1:0]            shift_amt;
   logic [N-1:0]             sml_aligned;
   logic [N:0]               big_ext;
   logic [N:0]               sml_ext;

   // Signed regime above the exponent bits
   function automatic logic [SW-1:0] signed_scale(input posit_pkg::posit_fields_t f);
      logic [BS:0] reg_val;
      reg_val = f.regime_pos ? {1'b0, f.regime} : -{1'b0, f.regime};
      return {reg_val, f.exp};
   endfunction

   ////////////////////////////////////////////////////////////
   // Operand order
   ////////////////////////////////////////////////////////////

   // Posit magnitudes order like integers, a wins a tie
   assign a_big  = a_mag_i[N-2:0] >= b_mag_i[N-2:0];
   assign op_big = a_big ? a_i : b_i;
   assign op_sml = a_big ? b_i : a_i;

   assign big_scale = signed_scale(op_big);
   assign sml_scale = signed_scale(op_sml);

   ////////////////////////////////////////////////////////////
   // Alignment
   ////////////////////////////////////////////////////////////

   // Below 256 for nonzero operands, so 8 bits are exact
   // A zero small operand may wrap here but has no fraction to shift
   assign scale_diff = big_scale - sml_scale;

   // Saturate at 31
   assign shift_amt = |scale_diff[SW-1:BS] ? {BS{1'b1}} : scale_diff[BS-1:0];

   barrel_shifter #(.WIDTH(N), .SHIFT_LEFT(1'b0)) u_shr (
      .data_i  ({op_sml.frac, 1'b0}),
      .amount_i(shift_amt),
      .data_o  (sml_aligned)
   );

   // Carry room on top, one extra bit below the fraction
   assign big_ext = {1'b0, op_big.frac, 1'b0};
   assign sml_ext = {1'b0, sml_aligned};

   assign sum_o.sign  = op_big.sign;
   assign sum_o.scale = big_scale;
   // Opposite signs subtract, never negative since big is larger
   assign sum_o.sum   = (op_big.sign == op_sml.sign) ? big_ext + sml_ext : big_ext - sml_ext;

endmodule

`default_nettype wire

/* src/posit_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module posit_decode (
   input  posit_pkg::posit_t        word_i,
   output posit_pkg::posit_fields_t fields_o
);

   localparam int N  = `POSIT_N;
   localparam int ES = `POSIT_ES;
   localparam int BS = `POSIT_BS;

   posit_pkg::posit_t mag;
   posit_pkg::posit_t run_word;
   logic [BS-1:0]     run_len;
   logic              hidden;
   logic [N-1:0]      body;

   // Magnitude
   assign mag = word_i[N-1] ? -word_i : word_i;

   // Ones run flipped to zeros, one detector serves both
   assign run_word = mag[N-2] ? ~mag : mag;

   ////////////////////////////////////////////////////////////
   // Regime run length
   ////////////////////////////////////////////////////////////

   // LSB is the run bit so an all-ones word stops at 31
   // Any one found here means a nonzero, non-NaR operand
   leading_one_detect #(.WIDTH(N)) u_lod (
      .in_i   ({run_word[N-2:0], mag[N-2]}),
      .count_o(run_len),
      .valid_o(hidden)
   );

   // Sign and first run bit dropped up front
   // Shift removes the rest of the run and the terminator
   barrel_shifter #(.WIDTH(N), .SHIFT_LEFT(1'b1)) u_shl (
      .data_i  ({mag[N-3:0], 2'b00}),
      .amount_i(run_len),
      .data_o  (body)
   );

   ////////////////////////////////////////////////////////////
   // Fields
   ////////////////////////////////////////////////////////////

   assign fields_o.sign       = word_i[N-1];
   assign fields_o.regime_pos = mag[N-2];
   // k ones mean k-1, k zeros mean -k
   assign fields_o.regime     = mag[N-2] ? run_len - 1'b1 : run_len;
   assign fields_o.exp        = body[N-1 -: ES];
   assign fields_o.frac       = {hidden, body[N-ES-1:0]};

endmodule

`default_nettype wire

/* src/barrel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_params.svh"

module barrel_shifter #(
   parameter int WIDTH      = 32,
   parameter bit SHIFT_LEFT = 1'b1
) (
   input  logic [WIDTH-1:0]     data_i,
   input  logic [`POSIT_BS-1:0] amount_i,
   output logic [WIDTH-1:0]     data_o
);

   // Stage 0 is the input, one more stage per amount bit
   logic [WIDTH-1:0] stage [0:`POSIT_BS];

   assign stage[0] = data_i;

   generate
      for (genvar i = 0; i < `POSIT_BS; i++)
      begin : g_stage
         // Stage i moves by 2^i, zero fill
         if (SHIFT_LEFT)
         begin : g_left
            assign stage[i+1] = amount_i[i] ? stage[i] << (1 << i) : stage[i];
         end
         else
         begin : g_right
            assign stage[i+1] = amount_i[i] ? stage[i] >> (1 << i) : stage[i];
         end
      end
   endgenerate

   assign data_o = stage[`POSIT_BS];

endmodule

`default_nettype wire

/* src/leading_one_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module leading_one_detect #(
   parameter int WIDTH = 32
) (
   input  logic [WIDTH-1:0]         in_i,
   output logic [$clog2(WIDTH)-1:0] count_o,
   output logic                     valid_o
);

   localparam int CW = $clog2(WIDTH);

   generate
      if (WIDTH == 2)
      begin : g_leaf
         // One zero above the one only when the upper bit is clear
         assign count_o = ~in_i[1] & in_i[0];
         assign valid_o = in_i[1] | in_i[0];
      end
      else
      begin : g_split
         logic [CW-2:0] hi_count;
         logic [CW-2:0] lo_count;
         logic          hi_valid;
         logic          lo_valid;

         // Upper half
         leading_one_detect #(.WIDTH(WIDTH/2)) u_hi (
            .in_i   (in_i[WIDTH-1:WIDTH/2]),
            .count_o(hi_count),
            .valid_o(hi_valid)
         );

         // Lower half
         leading_one_detect #(.WIDTH(WIDTH/2)) u_lo (
            .in_i   (in_i[WIDTH/2-1:0]),
            .count_o(lo_count),
            .valid_o(lo_valid)
         );

         assign valid_o = hi_valid | lo_valid;
         // Empty upper half adds its whole width to the lower count
         assign count_o = hi_valid ? {1'b0, hi_count} : {lo_valid, lo_count};
      end
   endgenerate

endmodule

`default_nettype wire

/* src/posit_pkg.sv */
`default_nettype none

`include "posit_params.svh"

package posit_pkg;

   // One posit word
   typedef logic [`POSIT_N-1:0] posit_t;

   // Decoded operand, sign on top
   typedef struct packed {
      logic                        sign;
      // Run bit, 1 for a run of ones
      logic                        regime_pos;
      // Regime magnitude
      logic [`POSIT_BS-1:0]        regime;
      logic [`POSIT_ES-1:0]        exp;
      // Hidden bit then fraction
      logic [`POSIT_N-`POSIT_ES:0] frac;
   } posit_fields_t;

   // Aligned fraction sum for normalization
   typedef struct packed {
      // Sign of the larger operand
      logic                      sign;
      // Signed scale of the larger operand
      logic [`POSIT_SCALE_W-1:0] scale;
      // Carry on top
      logic [`POSIT_N:0]         sum;
   } posit_sum_t;

endpackage

`default_nettype wire

/* include/posit_params.svh */
`ifndef POSIT_PARAMS_SVH
`define POSIT_PARAMS_SVH

// Posit word width
`define POSIT_N 32

// Exponent field width
`define POSIT_ES 2

// Regime values and shift amounts, log2 of the word width
`define POSIT_BS 5

// Signed scale, regime joined above the exponent
`define POSIT_SCALE_W (`POSIT_ES + `POSIT_BS + 1)

// Not a Real, sign bit alone
`define POSIT_NAR {1'b1, {(`POSIT_N-1){1'b0}}}

`endif
